// ==== sources.f ====
+incdir+.
mem_pkg.sv
mesi_pkg.sv
l1_dcache.sv
bus_arbiter.sv
coherence_bus.sv
l2_memory.sv
coh_subsystem_top.sv
tb_coh_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MESI subsystem testbench with Verilator and run it.
# The run passes only if the simulation prints the pass line.

verilator --binary --timing --assert -j 0 \
    --top-module tb_coh_subsystem -f sources.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "sim passed" \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

// ==== tb_coh_subsystem.sv ====
// Testbench for the two-cache MESI subsystem
// Reference memory and per-cache MESI model, directed and random accesses
`timescale 1ns/100ps
`include "coh_cfg.svh"

module tb_coh_subsystem;
    import mem_pkg::*;
    import mesi_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECTED   = 15;   // Accesses in tests 1 to 5
    localparam int N_RAND       = 300;
    localparam int MISS_BOUND   = 30;   // Worst-case cycles per access
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 10 + (N_DIRECTED + N_RAND) * MISS_BOUND)
                                  * CLK_PERIOD;
    localparam int IDX_W        = $clog2(`L1_SETS);

    logic     CLK;
    logic     arst_n;
    cpu_req_t cpu_req [`CPUS];
    cpu_rsp_t cpu_rsp [`CPUS];

    // Reference state
    word_t       ref_mem [64];              // Word image of addresses below 256
    addr_t       tag_m   [`CPUS][`L1_SETS];
    line_state_e st_m    [`CPUS][`L1_SETS];

    integer seed;
    string  test_name;
    int     n_access;

    coh_subsystem_top uut (
        .CLK     (CLK),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    initial begin : clock_gen
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // MESI rules per access; returns whether a one-cycle hit is expected
    function automatic bit model_access(input int c, input bit wr, input addr_t a);
        int    o;
        int    s;
        addr_t t;
        bit    mine;
        bit    theirs;
        bit    hit;
        o      = 1 - c;                     // The other cache
        s      = int'(a[3 +: IDX_W]);
        t      = a >> (3 + IDX_W);
        mine   = (st_m[c][s] != INVALID) && (tag_m[c][s] == t);
        theirs = (st_m[o][s] != INVALID) && (tag_m[o][s] == t);
        if (!wr) begin
            hit = mine;
            if (!mine && theirs) begin
                st_m[o][s] = SHARED;        // M or E drops to S on BusRd
                st_m[c][s] = SHARED;
            end else if (!mine) begin
                st_m[c][s] = EXCLUSIVE;     // No other copy
            end
        end else begin
            hit = mine && (st_m[c][s] == EXCLUSIVE || st_m[c][s] == MODIFIED);
            if (theirs) st_m[o][s] = INVALID;  // RdX or Upgr invalidates
            st_m[c][s] = MODIFIED;
        end
        tag_m[c][s] = t;                    // Victim simply replaced
        return hit;
    endfunction

    // Pool of 16 addresses, four tags over sets 0 and 1, both words
    function automatic addr_t pool_addr(input logic [3:0] k);
        return addr_t'({k[3:2], 2'b00, k[1], k[0], 2'b00});
    endfunction

    task automatic check_word(input int c, input addr_t a, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("Error: %s cpu%0d addr %h rdata expected %h actual %h",
                     test_name, c, a, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_hit(input int c, input addr_t a, input bit exp_hit, input int lat);
        assert ((lat == 1) == exp_hit) else begin
            $display("Error: %s cpu%0d addr %h one-cycle hit expected %0d actual %0d (%0d cycles)",
                     test_name, c, a, exp_hit, lat == 1, lat);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // One strobe, then wait for done; entered and left 1 ns after a rising edge
    task automatic run_access(input int c, input bit wr, input addr_t a, input word_t wd);
        bit    exp_hit;
        int    lat;
        word_t exp_rd;
        exp_hit = model_access(c, wr, a);
        exp_rd  = ref_mem[a[7:2]];
        cpu_req[c].ren   = !wr;
        cpu_req[c].wen   = wr;
        cpu_req[c].addr  = a;
        cpu_req[c].wdata = wd;
        @(posedge CLK);
        #1;
        cpu_req[c].ren = 1'b0;              // Strobe lasts one cycle
        cpu_req[c].wen = 1'b0;
        lat = 1;
        while (!cpu_rsp[c].done) begin      // Watchdog bounds this loop
            @(posedge CLK);
            #1;
            lat++;
        end
        check_hit(c, a, exp_hit, lat);
        if (wr) ref_mem[a[7:2]] = wd;
        else check_word(c, a, exp_rd, cpu_rsp[c].rdata);
        n_access++;
    endtask

    task automatic cpu_read(input int c, input addr_t a);
        run_access(c, 1'b0, a, '0);
    endtask

    task automatic cpu_write(input int c, input addr_t a, input word_t d);
        run_access(c, 1'b1, a, d);
    endtask

    initial begin : stimulus
        integer r;
        addr_t  a;
        seed     = 32'h0f05a493;
        n_access = 0;
        for (int c = 0; c < `CPUS; c++) begin
            cpu_req[c] = '0;
            for (int s = 0; s < `L1_SETS; s++) begin
                tag_m[c][s] = '0;
                st_m[c][s]  = INVALID;
            end
        end
        for (int i = 0; i < 64; i++) ref_mem[i] = '0;   // L2 clears at reset
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        arst_n = 1'b1;
        repeat (2) @(posedge CLK);
        #1;

        test_name = "cold_read";
        cpu_read(0, 32'h000);               // Miss, returns 0
        cpu_read(0, 32'h000);               // Now a hit

        test_name = "exclusive_write";
        cpu_read(0, 32'h008);               // Line in E
        cpu_write(0, 32'h00C, 32'ha5a5_0001); // Silent E to M
        cpu_read(0, 32'h00C);

        test_name = "dirty_sharing";
        cpu_write(0, 32'h040, 32'h1234_5678);
        cpu_read(1, 32'h040);               // Data from CPU0 cache
        cpu_write(0, 32'h044, 32'h0bad_cafe); // S needs an upgrade

        test_name = "invalidation";
        cpu_read(0, 32'h088);               // Also evicts the M line of set 1
        cpu_read(1, 32'h088);
        cpu_write(1, 32'h088, 32'h5566_7788);
        cpu_read(0, 32'h088);               // Invalidated, so a miss

        test_name = "eviction_writeback";
        cpu_write(0, 32'h0D0, 32'hdead_beef);
        cpu_read(0, 32'h010);               // Same set, M victim written back
        cpu_read(1, 32'h0D0);

        test_name = "random_mix";
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            a = pool_addr(r[3:0]);
            if (r[5]) cpu_write(int'(r[4]), a, $random(seed));
            else cpu_read(int'(r[4]), a);
        end

        $display("Completed %0d accesses", n_access);
        $display("sim passed");
        $finish;
    end

    // Ends a run that stops making progress
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: accesses did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $fatal(1);
    end

endmodule

// ==== coh_subsystem_top.sv ====
// Top level with two L1 caches, bus arbiter, coherence bus controller and L2
`timescale 1ns/100ps
`include "coh_cfg.svh"

module coh_subsystem_top (
    input  logic               CLK,
    input  logic               arst_n,
    input  mem_pkg::cpu_req_t  cpu_req [`CPUS],
    output mem_pkg::cpu_rsp_t  cpu_rsp [`CPUS]
);
    import mem_pkg::*;
    import mesi_pkg::*;

    bus_req_t                  bus_req   [`CPUS];
    bus_rsp_t                  bus_rsp   [`CPUS];
    snoop_t                    snoop     [`CPUS];
    snoop_rsp_t                snoop_rsp [`CPUS];
    logic [`CPUS-1:0]          req_vec;
    logic [`CPUS-1:0]          grant;
    logic [$clog2(`CPUS)-1:0]  owner;
    logic                      bus_done;   // Release for the arbiter
    l2_req_t                   l2_req;
    l2_rsp_t                   l2_rsp;

    assign bus_done = bus_rsp[0].done | bus_rsp[1].done;

    for (genvar i = 0; i < `CPUS; i++) begin : g_cache
        assign req_vec[i] = bus_req[i].req;

        l1_dcache u_l1 (
            .CLK       (CLK),
            .arst_n    (arst_n),
            .cpu_req   (cpu_req[i]),
            .cpu_rsp   (cpu_rsp[i]),
            .bus_req   (bus_req[i]),
            .bus_rsp   (bus_rsp[i]),
            .snoop     (snoop[i]),
            .snoop_rsp (snoop_rsp[i])
        );
    end

    bus_arbiter u_arb (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .req      (req_vec),
        .bus_done (bus_done),
        .grant    (grant),
        .owner    (owner)
    );

    coherence_bus u_bus (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .bus_req   (bus_req),
        .grant     (grant),
        .owner     (owner),
        .bus_rsp   (bus_rsp),
        .snoop     (snoop),
        .snoop_rsp (snoop_rsp),
        .l2_req    (l2_req),
        .l2_rsp    (l2_rsp)
    );

    l2_memory u_l2 (
        .CLK    (CLK),
        .arst_n (arst_n),
        .l2_req (l2_req),
        .l2_rsp (l2_rsp)
    );

endmodule

// ==== l2_memory.sv ====
// L2 backing store of two-word blocks with fixed access latency
`timescale 1ns/100ps
`include "coh_cfg.svh"

module l2_memory (
    input  logic              CLK,
    input  logic              arst_n,
    input  mem_pkg::l2_req_t  l2_req,
    output mem_pkg::l2_rsp_t  l2_rsp
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`L2_DEPTH);
    localparam int CNT_W = $clog2(`L2_LATENCY + 1);

    block_t           mem_q [`L2_DEPTH];
    logic [CNT_W-1:0] cnt_q;     // Cycles left before done
    logic             we_q;
    logic [IDX_W-1:0] idx_q;
    block_t           wdata_q;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `L2_DEPTH; i++) mem_q[i] <= '0;
            cnt_q        <= '0;
            we_q         <= 1'b0;
            idx_q        <= '0;
            wdata_q      <= '0;
            l2_rsp.done  <= 1'b0;
            l2_rsp.rdata <= '0;
        end else begin
            l2_rsp.done <= 1'b0;
            if (l2_req.valid) begin
                cnt_q   <= CNT_W'(`L2_LATENCY - 1);  // Done lands L2_LATENCY after valid
                we_q    <= l2_req.we;
                idx_q   <= l2_req.addr[3 +: IDX_W];
                wdata_q <= l2_req.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    l2_rsp.done <= 1'b1;
                    if (we_q) mem_q[idx_q] <= wdata_q;
                    l2_rsp.rdata <= mem_q[idx_q];
                end
            end
        end
    end

endmodule

// ==== coherence_bus.sv ====
// Bus controller FSM with snoop broadcast and cache-to-cache or L2 data source
// Dirty-data and eviction writeback to L2
`timescale 1ns/100ps
`include "coh_cfg.svh"

module coherence_bus (
    input  logic                      CLK,
    input  logic                      arst_n,
    input  mesi_pkg::bus_req_t        bus_req   [`CPUS],
    input  logic [`CPUS-1:0]          grant,
    input  logic [$clog2(`CPUS)-1:0]  owner,
    output mesi_pkg::bus_rsp_t        bus_rsp   [`CPUS],
    output mesi_pkg::snoop_t          snoop     [`CPUS],
    input  mesi_pkg::snoop_rsp_t      snoop_rsp [`CPUS],
    output mem_pkg::l2_req_t          l2_req,
    input  mem_pkg::l2_rsp_t          l2_rsp
);
    import mem_pkg::*;
    import mesi_pkg::*;

    localparam int IW = $clog2(`CPUS);

    typedef enum logic [2:0] {
        IDLE, SNOOP, SNOOP_WAIT, L2_WRITE, L2_READ, RESPOND
    } fsm_e;

    fsm_e        fsm_q;
    logic [IW-1:0] own_q;
    logic [IW-1:0] other;    // The single snooper
    bus_cmd_e    cmd_q;
    addr_t       addr_q;
    block_t      fill_q;
    line_state_e gstate_q;
    snoop_rsp_t  srsp;

    assign other = own_q ^ 1'b1;  // Two caches only
    assign srsp  = snoop_rsp[other];

    // Outputs decoded from FSM state
    always_comb begin
        for (int i = 0; i < `CPUS; i++) begin
            bus_rsp[i].done        = (fsm_q == RESPOND) && (own_q == IW'(i));
            bus_rsp[i].fill        = fill_q;
            bus_rsp[i].grant_state = gstate_q;
            snoop[i].valid         = (fsm_q == SNOOP) && (other == IW'(i));
            snoop[i].cmd           = cmd_q;
            snoop[i].addr          = addr_q;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            fsm_q        <= IDLE;
            own_q        <= '0;
            cmd_q        <= BUS_RD;
            gstate_q     <= INVALID;
            l2_req.valid <= 1'b0;
            l2_req.we    <= 1'b0;
        end else begin
            l2_req.valid <= 1'b0;
            case (fsm_q)
                IDLE: begin
                    if (|grant) begin
                        own_q <= owner;
                        cmd_q <= bus_req[owner].cmd;
                        if (bus_req[owner].cmd == BUS_WB) begin
                            l2_req.valid <= 1'b1;   // Eviction goes straight to L2
                            l2_req.we    <= 1'b1;
                            fsm_q        <= L2_WRITE;
                        end else begin
                            fsm_q <= SNOOP;
                        end
                    end
                end
                SNOOP: fsm_q <= SNOOP_WAIT;
                SNOOP_WAIT: begin
                    if (cmd_q == BUS_RD) gstate_q <= srsp.hit ? SHARED : EXCLUSIVE;
                    else gstate_q <= MODIFIED;
                    if (srsp.hit && srsp.dirty) begin
                        l2_req.valid <= 1'b1;       // Dirty data also to L2
                        l2_req.we    <= 1'b1;
                        fsm_q        <= L2_WRITE;
                    end else if (srsp.hit && cmd_q == BUS_RD) begin
                        fsm_q <= RESPOND;           // Clean cache-to-cache
                    end else begin
                        l2_req.valid <= 1'b1;
                        l2_req.we    <= 1'b0;
                        fsm_q        <= L2_READ;
                    end
                end
                L2_WRITE: if (l2_rsp.done) fsm_q <= RESPOND;
                L2_READ:  if (l2_rsp.done) fsm_q <= RESPOND;
                RESPOND:  fsm_q <= IDLE;
                default:  fsm_q <= IDLE;
            endcase
        end
    end

    // Address, fill and L2 write payload
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            addr_q       <= '0;
            fill_q       <= '0;
            l2_req.addr  <= '0;
            l2_req.wdata <= '0;
        end else begin
            if (fsm_q == IDLE && (|grant)) begin
                addr_q       <= bus_req[owner].addr;
                l2_req.addr  <= bus_req[owner].addr;
                l2_req.wdata <= bus_req[owner].wdata;
            end
            if (fsm_q == SNOOP_WAIT && srsp.hit) begin
                fill_q       <= srsp.data;
                l2_req.wdata <= srsp.data;
            end
            if (fsm_q == L2_READ && l2_rsp.done) fill_q <= l2_rsp.rdata;
        end
    end

endmodule

// ==== bus_arbiter.sv ====
// Round-robin arbiter for the shared coherence bus
`timescale 1ns/100ps
`include "coh_cfg.svh"

module bus_arbiter (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic [`CPUS-1:0]            req,
    input  logic                        bus_done,  // End of the current transaction
    output logic [`CPUS-1:0]            grant,
    output logic [$clog2(`CPUS)-1:0]    owner
);
    localparam int IW = $clog2(`CPUS);

    logic [IW-1:0] prio_q;   // Highest priority cache
    logic [IW-1:0] pick;
    logic          found;

    // First requester at or after the priority pointer
    always_comb begin
        logic [IW-1:0] cand;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < `CPUS; i++) begin
            cand = IW'((int'(prio_q) + i) % `CPUS);
            if (!found && req[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            grant  <= '0;
            owner  <= '0;
            prio_q <= '0;
        end else if (|grant) begin
            if (bus_done) begin
                grant  <= '0;    // Held until the transaction ends
                prio_q <= (owner == IW'(`CPUS-1)) ? '0 : owner + 1'b1;
            end
        end else if (found) begin
            grant       <= '0;
            grant[pick] <= 1'b1;
            owner       <= pick;
        end
    end

endmodule

// ==== l1_dcache.sv ====
// Direct-mapped write-back L1 data cache with MESI state per line
// Miss FSM toward the coherence bus and a parallel snoop responder
`timescale 1ns/100ps
`include "coh_cfg.svh"

module l1_dcache (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  mem_pkg::cpu_req_t     cpu_req,
    output mem_pkg::cpu_rsp_t     cpu_rsp,
    output mesi_pkg::bus_req_t    bus_req,
    input  mesi_pkg::bus_rsp_t    bus_rsp,
    input  mesi_pkg::snoop_t      snoop,
    output mesi_pkg::snoop_rsp_t  snoop_rsp
);
    import mem_pkg::*;
    import mesi_pkg::*;

    localparam int IDX_W = $clog2(`L1_SETS);
    localparam int TAG_W = `ADDR_W - IDX_W - 3;  // 3 offset bits per 8-byte block

    typedef enum logic [1:0] {IDLE, WRITEBACK, FILL, RESPOND} fsm_e;

    logic [TAG_W-1:0] tag_q   [`L1_SETS];
    block_t           data_q  [`L1_SETS];
    line_state_e      state_q [`L1_SETS];

    fsm_e     fsm_q;
    bus_cmd_e cmd_q;     // Fill command of the pending miss
    addr_t    addr_q;    // Pending request
    word_t    wdata_q;
    logic     we_q;

    // Replace one word of a block
    function automatic block_t merge(block_t blk, logic sel, word_t w);
        block_t res;
        res = blk;
        if (sel) res[63:32] = w;
        else res[31:0] = w;
        return res;
    endfunction

    // CPU side lookup
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             tag_hit, strobe, hit_rd, hit_wr;
    line_state_e      cur_st;
    block_t           wr_blk;

    assign idx     = cpu_req.addr[3 +: IDX_W];
    assign tag     = cpu_req.addr[`ADDR_W-1 -: TAG_W];
    assign cur_st  = state_q[idx];
    assign tag_hit = (tag_q[idx] == tag) && (cur_st != INVALID);
    assign strobe  = (fsm_q == IDLE) && (cpu_req.ren || cpu_req.wen); // Busy strobes dropped
    assign hit_rd  = strobe && cpu_req.ren && tag_hit;
    assign hit_wr  = strobe && cpu_req.wen && tag_hit &&
                     (cur_st == EXCLUSIVE || cur_st == MODIFIED);
    assign wr_blk  = merge(data_q[idx], cpu_req.addr[2], cpu_req.wdata);

    // Pending miss view
    logic [IDX_W-1:0] pidx;
    block_t           fill_blk;
    assign pidx     = addr_q[3 +: IDX_W];
    assign fill_blk = we_q ? merge(bus_rsp.fill, addr_q[2], wdata_q) : bus_rsp.fill;

    // Snoop side; a CPU write hit in the same cycle is ordered first
    logic [IDX_W-1:0] sidx;
    logic             same_line, snp_hit;
    line_state_e      snp_st;
    block_t           snp_blk;

    assign sidx      = snoop.addr[3 +: IDX_W];
    assign same_line = hit_wr && (idx == sidx);
    assign snp_st    = same_line ? MODIFIED : state_q[sidx];
    assign snp_blk   = same_line ? wr_blk : data_q[sidx];
    assign snp_hit   = (snp_st != INVALID) &&
                       (tag_q[sidx] == snoop.addr[`ADDR_W-1 -: TAG_W]);

    // Bus request follows the FSM, so it drops the cycle after done
    assign bus_req.req   = (fsm_q == WRITEBACK) || (fsm_q == FILL);
    assign bus_req.cmd   = (fsm_q == WRITEBACK) ? BUS_WB : cmd_q;
    assign bus_req.addr  = (fsm_q == WRITEBACK) ? {tag_q[pidx], pidx, 3'b000}
                                                : {addr_q[`ADDR_W-1:3], 3'b000};
    assign bus_req.wdata = data_q[pidx];  // Victim block

    // Miss FSM and completion strobe
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            fsm_q        <= IDLE;
            cmd_q        <= BUS_RD;
            cpu_rsp.done <= 1'b0;
        end else begin
            cpu_rsp.done <= 1'b0;
            case (fsm_q)
                IDLE: begin
                    if (hit_rd || hit_wr) begin
                        cpu_rsp.done <= 1'b1;           // One-cycle hit
                    end else if (strobe) begin
                        if (cpu_req.wen && tag_hit) cmd_q <= BUS_UPGR; // Line in S
                        else if (cpu_req.wen)       cmd_q <= BUS_RDX;
                        else                        cmd_q <= BUS_RD;
                        if (!tag_hit && cur_st == MODIFIED) fsm_q <= WRITEBACK;
                        else fsm_q <= FILL;
                    end
                end
                WRITEBACK: if (bus_rsp.done) fsm_q <= FILL;
                FILL:      if (bus_rsp.done) fsm_q <= RESPOND;
                RESPOND: begin
                    cpu_rsp.done <= 1'b1;
                    fsm_q        <= IDLE;
                end
                default: fsm_q <= IDLE;
            endcase
        end
    end

    // Request capture and read data
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            addr_q        <= '0;
            wdata_q       <= '0;
            we_q          <= 1'b0;
            cpu_rsp.rdata <= '0;
        end else begin
            if (strobe) begin
                addr_q  <= cpu_req.addr;
                wdata_q <= cpu_req.wdata;
                we_q    <= cpu_req.wen;
            end
            if (hit_rd)
                cpu_rsp.rdata <= cpu_req.addr[2] ? data_q[idx][63:32] : data_q[idx][31:0];
            else if (fsm_q == RESPOND)
                cpu_rsp.rdata <= addr_q[2] ? data_q[pidx][63:32] : data_q[pidx][31:0];
        end
    end

    // Tag and data arrays
    always_ff @(posedge CLK) begin
        if (hit_wr) data_q[idx] <= wr_blk;
        if (fsm_q == FILL && bus_rsp.done) begin
            data_q[pidx] <= fill_blk;              // Write word merged after fill
            tag_q[pidx]  <= addr_q[`ADDR_W-1 -: TAG_W];
        end
    end

    // Line states; snoop transition goes last and wins
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `L1_SETS; i++) state_q[i] <= INVALID;
        end else begin
            if (hit_wr) state_q[idx] <= MODIFIED;   // E -> M silently
            if (fsm_q == WRITEBACK && bus_rsp.done) state_q[pidx] <= INVALID;
            if (fsm_q == FILL && bus_rsp.done) state_q[pidx] <= bus_rsp.grant_state;
            if (snoop.valid && snp_hit) begin
                if (snoop.cmd == BUS_RD) begin
                    if (snp_st == MODIFIED || snp_st == EXCLUSIVE) state_q[sidx] <= SHARED;
                end else begin
                    state_q[sidx] <= INVALID;       // RdX or Upgr
                end
            end
        end
    end

    // Snoop answer one cycle after the strobe
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            snoop_rsp.hit   <= 1'b0;
            snoop_rsp.dirty <= 1'b0;
            snoop_rsp.data  <= '0;
        end else begin
            snoop_rsp.hit   <= snoop.valid && snp_hit;
            snoop_rsp.dirty <= snoop.valid && snp_hit && (snp_st == MODIFIED);
            if (snoop.valid) snoop_rsp.data <= snp_blk;
        end
    end

endmodule

// ==== mesi_pkg.sv ====
// Coherence line state, bus command, bus request/response and snoop structs
package mesi_pkg;

    import mem_pkg::*;

    // MESI line state
    typedef enum logic [1:0] {
        INVALID,
        SHARED,
        EXCLUSIVE,
        MODIFIED
    } line_state_e;

    // Bus transaction type
    typedef enum logic [1:0] {
        BUS_RD,
        BUS_RDX,
        BUS_UPGR,
        BUS_WB
    } bus_cmd_e;

    // Cache to bus, req held until bus done
    typedef struct packed {
        logic     req;
        bus_cmd_e cmd;
        addr_t    addr;
        block_t   wdata;  // Only for BUS_WB
    } bus_req_t;

    // Bus answer to the owner
    typedef struct packed {
        logic        done;
        block_t      fill;
        line_state_e grant_state;
    } bus_rsp_t;

    typedef struct packed {
        logic     valid;
        bus_cmd_e cmd;
        addr_t    addr;
    } snoop_t;

    // Answer one cycle after the snoop strobe
    typedef struct packed {
        logic   hit;
        logic   dirty;
        block_t data;
    } snoop_rsp_t;

endpackage

// ==== mem_pkg.sv ====
// Data-path vector types, processor and L2 request/response structs
`include "coh_cfg.svh"

package mem_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;  // Byte address
    typedef logic [31:0]        word_t;  // Data word
    typedef logic [63:0]        block_t; // Two words, word 0 low

    // Processor request, single-cycle strobe
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  done;   // One-cycle completion strobe
        word_t rdata;  // Valid with done
    } cpu_rsp_t;

    // L2 request, single-cycle strobe
    typedef struct packed {
        logic   valid;
        logic   we;
        addr_t  addr;
        block_t wdata;
    } l2_req_t;

    typedef struct packed {
        logic   done;
        block_t rdata;
    } l2_rsp_t;

endpackage

// ==== coh_cfg.svh ====
// Configuration macros for the MESI coherence subsystem
// CPU count, address width, L1 geometry and L2 size/latency
`ifndef COH_CFG_SVH
`define COH_CFG_SVH

// Number of caches on the coherence bus (snoop fan-in is built for two)
`define CPUS 2

// Byte address width
`define ADDR_W 32

// L1 lines per cache, direct-mapped
`define L1_SETS 8

// L2 blocks and cycles from request strobe to done
`define L2_DEPTH 64
`define L2_LATENCY 4

`endif
